/* common/draw_pkg.sv */
`default_nettype none

package draw_pkg;

  //////////////////////////////////////////////////
  // SDRAM side.
  localparam int addr_w = 24;                      // Bank, row and column bits.

  typedef logic [addr_w-1:0] pix_addr_t;           // y * width + x.
  typedef logic [15:0] color_t;                    // RGB565.

  //////////////////////////////////////////////////
  // Colour table.
  localparam color_t color_black  = 16'h0000;
  localparam color_t color_green  = 16'h07E0;
  localparam color_t color_yellow = 16'hFFE0;

  //////////////////////////////////////////////////
  // Command codes.
  typedef enum logic [3:0] {
    cmd_clear  = 4'd0,  // Whole screen black.
    cmd_frame  = 4'd1,  // Border lines and centre line.
    cmd_photon = 4'd5,  // Photon counter digits.
    cmd_accum  = 4'd8   // Accumulated counter digits.
  } cmd_t;

  //////////////////////////////////////////////////
  // Glyph geometry.
  localparam int digit_count = 8;   // Nibbles per counter.
  localparam int glyph_cols  = 8;   // Font bytes per glyph.
  localparam int glyph_bits  = 8;   // Pixels per font byte.
  localparam int font_digits = 10;  // Glyphs 0 to 9.

  // Upper nibble picks the digit, lower three bits the byte.
  typedef logic [6:0] font_addr_t;

endpackage

`default_nettype wire

/* glyph/font_rom.sv */
`default_nettype none

module font_rom (
  input  wire                         clk,
  input  wire draw_pkg::font_addr_t   font_addr,
  output logic [draw_pkg::glyph_bits-1:0] font_byte
);
  import draw_pkg::*;

  localparam int depth = font_digits * glyph_cols;  // 80 bytes.

  logic [glyph_bits-1:0] mem [depth];

  initial $readmemh("glyph/digit_font.hex", mem);

  // Registered read. Past the stored glyphs is blank.
  always_ff @(posedge clk) begin
    if (font_addr < font_addr_t'(depth))
      font_byte <= mem[font_addr];
    else
      font_byte <= '0;
  end

endmodule

`default_nettype wire

/* glyph/glyph_engine.sv */
`default_nettype none

module glyph_engine #(
  parameter int screen_width = 480
) (
  input  wire                      clk,
  input  wire                      rst_n,
  input  wire                      glyph_start,
  input  wire [31:0]               glyph_value,
  input  wire draw_pkg::pix_addr_t glyph_x,
  input  wire draw_pkg::pix_addr_t glyph_y,
  input  wire                      pix_ack,
  output logic                     glyph_busy,
  output logic                     pix_valid,
  output draw_pkg::pix_addr_t      pix_addr,
  output draw_pkg::color_t         pix_color
);
  import draw_pkg::*;

  localparam pix_addr_t row_step = pix_addr_t'(screen_width);

  typedef enum logic [1:0] {
    g_idle,
    g_wait,   // Font address settles into the ROM.
    g_load,   // Font byte available.
    g_draw    // Shifting out eight pixels.
  } state_t;

  state_t                state;
  logic [2:0]            digit_idx;
  logic [2:0]            col_idx;    // Font byte within glyph.
  logic [2:0]            bit_idx;
  logic [31:0]           value_q;    // Current digit in the top nibble.
  pix_addr_t             x_q;
  pix_addr_t             row_base;   // Screen row of the current byte.
  logic [glyph_bits-1:0] byte_q;
  logic [glyph_bits-1:0] font_byte;
  font_addr_t            font_addr;
  logic                  byte_end;
  logic                  last_byte;

  assign font_addr = {value_q[31:28], col_idx};  // Nibbles above 9 read blank.
  assign byte_end  = (bit_idx == 3'(glyph_bits - 1));
  assign last_byte = (col_idx == 3'(glyph_cols - 1)) && (digit_idx == 3'(digit_count - 1));

  font_rom font_i (
    .clk       (clk),
    .font_addr (font_addr),
    .font_byte (font_byte)
  );

  //////////////////////////////////////////////////
  // Sequencer. Order is digit, byte, bit.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state      <= g_idle;
      glyph_busy <= 1'b0;
      pix_valid  <= 1'b0;
      digit_idx  <= '0;
      col_idx    <= '0;
      bit_idx    <= '0;
    end else if (glyph_start) begin
      state      <= g_wait;
      glyph_busy <= 1'b1;
      digit_idx  <= '0;
      col_idx    <= '0;
    end else begin
      case (state)
        g_wait: state <= g_load;
        g_load: begin
          state     <= g_draw;
          pix_valid <= 1'b1;
          bit_idx   <= '0;                   // LSB first.
        end
        g_draw: begin
          if (pix_ack && !byte_end) begin
            bit_idx <= bit_idx + 3'd1;
          end else if (pix_ack) begin
            pix_valid <= 1'b0;                 // Gap while the next byte loads.
            if (last_byte) begin
              state      <= g_idle;
              glyph_busy <= 1'b0;
            end else begin
              state   <= g_wait;
              col_idx <= col_idx + 3'd1;       // Wraps to 0 on a new digit.
              if (col_idx == 3'(glyph_cols - 1))
                digit_idx <= digit_idx + 3'd1;
            end
          end
        end
        default: state <= g_idle;
      endcase
    end
  end

  // Pixel payload.
  always_ff @(posedge clk) begin
    if (glyph_start) begin
      value_q  <= glyph_value;
      x_q      <= glyph_x;
      row_base <= glyph_y * row_step;
    end else if (state == g_load) begin
      byte_q    <= font_byte;
      pix_addr  <= row_base + x_q;             // Bit 0 at the rightmost x.
      pix_color <= font_byte[0] ? color_green : color_black;
    end else if (state == g_draw && pix_ack) begin
      if (!byte_end) begin
        byte_q    <= byte_q >> 1;
        pix_addr  <= pix_addr - pix_addr_t'(1);  // Next bit one pixel left.
        pix_color <= byte_q[1] ? color_green : color_black;
      end else begin
        row_base <= row_base + row_step;       // Digits stack downwards.
        if (col_idx == 3'(glyph_cols - 1))
          value_q <= value_q << 4;
      end
    end
  end

endmodule

`default_nettype wire

/* raster/span_engine.sv */
`default_nettype none

module span_engine #(
  parameter int screen_width  = 480,
  parameter int screen_height = 800,
  parameter int frame_margin  = 10
) (
  input  wire                 clk,
  input  wire                 rst_n,
  input  wire                 span_start,
  input  wire                 span_fill,
  input  wire                 pix_ack,
  output logic                span_busy,
  output logic                pix_valid,
  output draw_pkg::pix_addr_t pix_addr,
  output draw_pkg::color_t    pix_color
);
  import draw_pkg::*;

  //////////////////////////////////////////////////
  // Run geometry.
  localparam pix_addr_t fill_last = pix_addr_t'(screen_width * screen_height - 1);
  localparam pix_addr_t col_step  = pix_addr_t'(screen_width);   // One row down.
  localparam pix_addr_t top_row   = pix_addr_t'(frame_margin * screen_width);
  localparam pix_addr_t bot_row   =
    pix_addr_t'((screen_height - 1 - frame_margin) * screen_width);
  localparam pix_addr_t left_x    = pix_addr_t'(frame_margin);
  localparam pix_addr_t right_x   = pix_addr_t'(screen_width - 1 - frame_margin);
  localparam pix_addr_t mid_x     = pix_addr_t'(screen_width / 2);

  logic       fill_q;
  logic [2:0] run_idx;   // 0..4 for frame.
  logic       at_end;
  logic       last_run;

  function automatic pix_addr_t run_first(input logic fill, input logic [2:0] idx);
    if (fill) return '0;
    case (idx)
      3'd0:    return top_row + left_x;   // Top row.
      3'd1:    return bot_row + left_x;   // Bottom row.
      3'd2:    return top_row + left_x;   // Left column.
      3'd3:    return top_row + right_x;  // Right column.
      default: return top_row + mid_x;    // Centre column.
    endcase
  endfunction

  function automatic pix_addr_t run_last(input logic fill, input logic [2:0] idx);
    if (fill) return fill_last;
    case (idx)
      3'd0:    return top_row + right_x;
      3'd1:    return bot_row + right_x;
      3'd2:    return bot_row + left_x;
      3'd3:    return bot_row + right_x;
      default: return bot_row + mid_x;
    endcase
  endfunction

  function automatic color_t run_color(input logic fill, input logic [2:0] idx);
    if (fill) return color_black;
    return (idx == 3'd4) ? color_yellow : color_green;
  endfunction

  assign at_end   = (pix_addr == run_last(fill_q, run_idx));
  assign last_run = fill_q || (run_idx == 3'd4);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      span_busy <= 1'b0;
      pix_valid <= 1'b0;
      fill_q    <= 1'b0;
      run_idx   <= '0;
    end else if (span_start) begin
      span_busy <= 1'b1;
      pix_valid <= 1'b1;   // First pixel out next cycle.
      fill_q    <= span_fill;
      run_idx   <= '0;
    end else if (pix_ack && at_end) begin
      if (last_run) begin
        span_busy <= 1'b0;
        pix_valid <= 1'b0;
      end else begin
        run_idx <= run_idx + 3'd1;
      end
    end
  end

  // Walk the address; rows step by one, columns by a row.
  always_ff @(posedge clk) begin
    if (span_start) begin
      pix_addr  <= run_first(span_fill, 3'd0);
      pix_color <= run_color(span_fill, 3'd0);
    end else if (pix_ack) begin
      if (at_end) begin
        pix_addr  <= run_first(fill_q, run_idx + 3'd1);
        pix_color <= run_color(fill_q, run_idx + 3'd1);
      end else if (fill_q || run_idx < 3'd2) begin
        pix_addr <= pix_addr + pix_addr_t'(1);
      end else begin
        pix_addr <= pix_addr + col_step;
      end
    end
  end

endmodule

`default_nettype wire

/* verilog/pixel_writer.sv */
`default_nettype none

module pixel_writer (
  input  wire                    clk,
  input  wire                    rst_n,
  input  wire                    sel_glyph,
  input  wire                    span_pix_valid,
  input  wire draw_pkg::pix_addr_t span_pix_addr,
  input  wire draw_pkg::color_t  span_pix_color,
  input  wire                    glyph_pix_valid,
  input  wire draw_pkg::pix_addr_t glyph_pix_addr,
  input  wire draw_pkg::color_t  glyph_pix_color,
  input  wire                    wr_done,
  output logic                   span_pix_ack,
  output logic                   glyph_pix_ack,
  output draw_pkg::pix_addr_t    wr_addr,
  output draw_pkg::color_t       wr_data,
  output logic                   wr_req
);
  import draw_pkg::*;

  logic      sel_valid;
  pix_addr_t sel_addr;
  color_t    sel_color;
  logic      write_ack;

  // Source mux.
  always_comb begin
    if (sel_glyph) begin
      sel_valid = glyph_pix_valid;
      sel_addr  = glyph_pix_addr;
      sel_color = glyph_pix_color;
    end else begin
      sel_valid = span_pix_valid;
      sel_addr  = span_pix_addr;
      sel_color = span_pix_color;
    end
  end

  assign write_ack     = wr_req && wr_done;  // One pixel retired.
  assign span_pix_ack  = write_ack && !sel_glyph;
  assign glyph_pix_ack = write_ack && sel_glyph;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_req <= 1'b0;
    end else if (write_ack) begin
      wr_req <= 1'b0;                        // Drop the cycle after done.
    end else if (!wr_req && sel_valid) begin
      wr_req <= 1'b1;
    end
  end

  // Address and data held for the whole request.
  always_ff @(posedge clk) begin
    if (!wr_req && sel_valid) begin
      wr_addr <= sel_addr;
      wr_data <= sel_color;
    end
  end

endmodule

`default_nettype wire

/* verilog/draw_cmd_decode.sv */
`default_nettype none

module draw_cmd_decode #(
  parameter int photon_x = 234,
  parameter int photon_y = 680,
  parameter int accum_x  = 180,
  parameter int accum_y  = 680
) (
  input  wire                 clk,
  input  wire                 rst_n,
  input  wire                 en,
  input  wire draw_pkg::cmd_t cmd,
  input  wire [31:0]          data,
  input  wire                 span_busy,
  input  wire                 glyph_busy,
  output logic                span_start,
  output logic                span_fill,    // Clear rather than frame.
  output logic                glyph_start,
  output logic [31:0]         glyph_value,
  output draw_pkg::pix_addr_t glyph_x,
  output draw_pkg::pix_addr_t glyph_y,
  output logic                sel_glyph,    // Writer listens to glyph engine.
  output logic                draw_done
);
  import draw_pkg::*;

  typedef enum logic [1:0] {
    st_idle,    // Waiting for en.
    st_launch,  // Start pulse out, busy not yet up.
    st_wait     // Engine running.
  } state_t;

  state_t state;
  logic   accept;

  assign accept = (state == st_idle) && en;

  //////////////////////////////////////////////////
  // Command FSM.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state       <= st_idle;
      span_start  <= 1'b0;
      glyph_start <= 1'b0;
      sel_glyph   <= 1'b0;
      draw_done   <= 1'b0;
    end else begin
      span_start  <= 1'b0;  // Strobes last one cycle.
      glyph_start <= 1'b0;
      draw_done   <= 1'b0;
      case (state)
        st_idle: begin
          if (en) begin
            case (cmd)
              cmd_clear, cmd_frame: begin
                span_start <= 1'b1;
                sel_glyph  <= 1'b0;
                state      <= st_launch;
              end
              cmd_photon, cmd_accum: begin
                glyph_start <= 1'b1;
                sel_glyph   <= 1'b1;
                state       <= st_launch;
              end
              default: state <= st_idle;  // Unknown code, stay put.
            endcase
          end
        end
        st_launch: state <= st_wait;
        st_wait: begin
          // Busy drops once the last pixel is acked.
          if (!span_busy && !glyph_busy) begin
            draw_done <= 1'b1;
            state     <= st_idle;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  // Operands for the engines.
  always_ff @(posedge clk) begin
    if (accept) begin
      span_fill   <= (cmd == cmd_clear);
      glyph_value <= data;
      glyph_x     <= (cmd == cmd_accum) ? pix_addr_t'(accum_x) : pix_addr_t'(photon_x);
      glyph_y     <= (cmd == cmd_accum) ? pix_addr_t'(accum_y) : pix_addr_t'(photon_y);
    end
  end

endmodule

`default_nettype wire

/* verilog/draw_core.sv */
`default_nettype none

module draw_core #(
  parameter int screen_width  = 480,
  parameter int screen_height = 800,
  parameter int frame_margin  = 10,
  parameter int photon_x      = 234,  // Rightmost x of photon counter.
  parameter int photon_y      = 680,
  parameter int accum_x       = 180,  // Rightmost x of accumulated counter.
  parameter int accum_y       = 680
) (
  input  wire                 clk,
  input  wire                 rst_n,
  input  wire                 en,
  input  wire draw_pkg::cmd_t cmd,
  input  wire [31:0]          data,
  output logic                draw_done,
  output draw_pkg::pix_addr_t wr_addr,
  output draw_pkg::color_t    wr_data,
  output logic                wr_req,
  input  wire                 wr_done
);
  import draw_pkg::*;

  // Decode to engines.
  logic        span_start;
  logic        span_fill;
  logic        glyph_start;
  logic [31:0] glyph_value;
  pix_addr_t   glyph_x;
  pix_addr_t   glyph_y;
  logic        sel_glyph;
  logic        span_busy;
  logic        glyph_busy;

  // Engine pixel streams.
  logic      span_pix_valid;
  pix_addr_t span_pix_addr;
  color_t    span_pix_color;
  logic      span_pix_ack;
  logic      glyph_pix_valid;
  pix_addr_t glyph_pix_addr;
  color_t    glyph_pix_color;
  logic      glyph_pix_ack;

  draw_cmd_decode #(
    .photon_x (photon_x),
    .photon_y (photon_y),
    .accum_x  (accum_x),
    .accum_y  (accum_y)
  ) decode_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .en          (en),
    .cmd         (cmd),
    .data        (data),
    .span_busy   (span_busy),
    .glyph_busy  (glyph_busy),
    .span_start  (span_start),
    .span_fill   (span_fill),
    .glyph_start (glyph_start),
    .glyph_value (glyph_value),
    .glyph_x     (glyph_x),
    .glyph_y     (glyph_y),
    .sel_glyph   (sel_glyph),
    .draw_done   (draw_done)
  );

  span_engine #(
    .screen_width  (screen_width),
    .screen_height (screen_height),
    .frame_margin  (frame_margin)
  ) span_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .span_start (span_start),
    .span_fill  (span_fill),
    .pix_ack    (span_pix_ack),
    .span_busy  (span_busy),
    .pix_valid  (span_pix_valid),
    .pix_addr   (span_pix_addr),
    .pix_color  (span_pix_color)
  );

  glyph_engine #(
    .screen_width (screen_width)
  ) glyph_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .glyph_start (glyph_start),
    .glyph_value (glyph_value),
    .glyph_x     (glyph_x),
    .glyph_y     (glyph_y),
    .pix_ack     (glyph_pix_ack),
    .glyph_busy  (glyph_busy),
    .pix_valid   (glyph_pix_valid),
    .pix_addr    (glyph_pix_addr),
    .pix_color   (glyph_pix_color)
  );

  pixel_writer writer_i (
    .clk             (clk),
    .rst_n           (rst_n),
    .sel_glyph       (sel_glyph),
    .span_pix_valid  (span_pix_valid),
    .span_pix_addr   (span_pix_addr),
    .span_pix_color  (span_pix_color),
    .glyph_pix_valid (glyph_pix_valid),
    .glyph_pix_addr  (glyph_pix_addr),
    .glyph_pix_color (glyph_pix_color),
    .wr_done         (wr_done),
    .span_pix_ack    (span_pix_ack),
    .glyph_pix_ack   (glyph_pix_ack),
    .wr_addr         (wr_addr),
    .wr_data         (wr_data),
    .wr_req          (wr_req)
  );

endmodule

`default_nettype wire

/* bench/draw_checker.sv */
`default_nettype none

module draw_checker #(
  parameter int screen_width  = 64,
  parameter int screen_height = 48,
  parameter int frame_margin  = 4,
  parameter int photon_x      = 60,
  parameter int photon_y      = 2,
  parameter int accum_x       = 40,
  parameter int accum_y       = 2
) (
  input wire                      clk,
  input wire                      rst_n,
  input wire                      en,
  input wire draw_pkg::cmd_t      cmd,
  input wire [31:0]               data,
  input wire                      draw_done,
  input wire draw_pkg::pix_addr_t wr_addr,
  input wire draw_pkg::color_t    wr_data,
  input wire                      wr_req,
  input wire                      wr_done
);
  import draw_pkg::*;

  localparam int row_len  = screen_width - 2 * frame_margin;   // Pixels per border row.
  localparam int col_len  = screen_height - 2 * frame_margin;  // Pixels per column.
  localparam int glyph_px = glyph_cols * glyph_bits;           // Pixels per digit.

  logic [7:0] font [font_digits * glyph_cols];

  int value_errors    = 0;
  int protocol_errors = 0;
  int writes_seen     = 0;

  logic        active;      // A command is being drawn.
  cmd_t        code_q;
  logic [31:0] word_q;
  int          idx;         // Next expected write.
  int          total;
  logic        first_wait;  // Waiting for the first wr_req.
  int          first_cnt;
  logic        tail_wait;   // Waiting for draw_done.
  int          tail_cnt;

  initial $readmemh("glyph/digit_font.hex", font);

  //////////////////////////////////////////////////
  // Reference model.
  function automatic int ref_count(input cmd_t code);
    case (code)
      cmd_clear:             return screen_width * screen_height;
      cmd_frame:             return 2 * row_len + 3 * col_len;
      cmd_photon, cmd_accum: return digit_count * glyph_px;
      default:               return 0;                         // Ignored code.
    endcase
  endfunction

  // Address and colour of write n, packed as {addr, color}.
  function automatic logic [39:0] ref_pixel(input cmd_t code, input logic [31:0] word,
                                            input int n);
    int         x;
    int         y;
    int         m;
    int         k;
    int         c;
    int         b;
    logic [3:0] nib;
    logic [7:0] fbyte;
    color_t     col;
    x   = n;
    y   = 0;
    col = color_black;                       // Clear walks every address.
    if (code == cmd_frame) begin
      col = color_green;
      if (n < row_len) begin
        y = frame_margin;                    // Top row.
        x = frame_margin + n;
      end else if (n < 2 * row_len) begin
        y = screen_height - 1 - frame_margin;  // Bottom row.
        x = frame_margin + n - row_len;
      end else begin
        m = n - 2 * row_len;
        y = frame_margin + m % col_len;      // Columns run top to bottom.
        case (m / col_len)
          0:       x = frame_margin;
          1:       x = screen_width - 1 - frame_margin;
          default: begin
            x   = screen_width / 2;          // Centre line.
            col = color_yellow;
          end
        endcase
      end
    end else if (code == cmd_photon || code == cmd_accum) begin
      k     = n / glyph_px;                  // Digit, MSB nibble first.
      c     = (n / glyph_bits) % glyph_cols;
      b     = n % glyph_bits;
      nib   = word[31 - 4 * k -: 4];
      fbyte = (int'(nib) < font_digits) ? font[int'(nib) * glyph_cols + c] : 8'h00;
      y     = ((code == cmd_accum) ? accum_y : photon_y) + k * glyph_cols + c;
      x     = ((code == cmd_accum) ? accum_x : photon_x) - b;
      col   = fbyte[b] ? color_green : color_black;
    end
    return {pix_addr_t'(y * screen_width + x), col};
  endfunction

  //////////////////////////////////////////////////
  // Write comparison.
  always @(posedge clk) begin : compare
    logic [39:0] want;
    if (!rst_n) begin
      active     = 1'b0;
      idx        = 0;
      total      = 0;
      first_wait = 1'b0;
      tail_wait  = 1'b0;
    end else begin
      if (draw_done) begin
        if (!active) begin
          $display("draw_done pulsed at %0t with no command running", $time);
          protocol_errors++;
        end else if (idx != total) begin
          $display("draw_done at %0t after only %0d of %0d writes", $time, idx, total);
          protocol_errors++;
        end
        active    = 1'b0;
        tail_wait = 1'b0;
      end
      if (tail_wait) begin
        tail_cnt++;
        if (tail_cnt >= 4) begin                 // Due 1 to 3 cycles after the last write.
          $display("draw_done missing at %0t after the last write", $time);
          protocol_errors++;
          tail_wait = 1'b0;
        end
      end
      if (first_wait) begin
        first_cnt++;
        if (wr_req) begin
          first_wait = 1'b0;
        end else if (first_cnt >= 5) begin       // Rises within 4, seen one edge later.
          $display("First wr_req late at %0t after command start", $time);
          protocol_errors++;
          first_wait = 1'b0;
        end
      end
      if (wr_req && wr_done) begin
        writes_seen++;
        if (!active || idx >= total) begin
          $display("Extra write to address 0x%06h at %0t", wr_addr, $time);
          protocol_errors++;
        end else begin
          want = ref_pixel(code_q, word_q, idx);
          if (wr_addr !== want[39:16]) begin
            $display("Error at %0t: wr_addr expected 0x%06h, actual 0x%06h (write %0d)",
                     $time, want[39:16], wr_addr, idx);
            value_errors++;
          end
          if (wr_data !== want[15:0]) begin
            $display("Error at %0t: wr_data expected 0x%04h, actual 0x%04h (write %0d)",
                     $time, want[15:0], wr_data, idx);
            value_errors++;
          end
          idx++;
          if (idx == total) begin
            tail_wait = 1'b1;
            tail_cnt  = 0;
          end
        end
      end
      if (!active && en && ref_count(cmd) != 0) begin  // Command accepted.
        active     = 1'b1;
        code_q     = cmd;
        word_q     = data;
        idx        = 0;
        total      = ref_count(cmd);
        first_wait = 1'b1;
        first_cnt  = 0;
      end
    end
  end

endmodule

`default_nettype wire

/* bench/draw_core_properties.sv */
`default_nettype none

module draw_core_properties (
  input wire                      clk,
  input wire                      rst_n,
  input wire                      wr_req,
  input wire draw_pkg::pix_addr_t wr_addr,
  input wire draw_pkg::color_t    wr_data,
  input wire                      wr_done,
  input wire                      draw_done
);

  //////////////////////////////////////////////////
  // SDRAM write handshake.
  a_req_hold: assert property (@(posedge clk) disable iff (!rst_n)
    wr_req && !wr_done |=> wr_req && $stable(wr_addr) && $stable(wr_data))
    else $error("wr_req or its payload changed before wr_done");

  // Request drops right after the answer.
  a_req_drop: assert property (@(posedge clk) disable iff (!rst_n)
    wr_req && wr_done |=> !wr_req)
    else $error("wr_req still high the cycle after wr_done");

  a_done_pulse: assert property (@(posedge clk) disable iff (!rst_n)
    draw_done |=> !draw_done)
    else $error("draw_done high for two cycles");

endmodule

`default_nettype wire

/* bench/draw_core_tb.sv */
`default_nettype none

module draw_core_tb;
  import draw_pkg::*;

  localparam int clk_period    = 100;
  localparam int screen_width  = 64;
  localparam int screen_height = 48;
  localparam int frame_margin  = 4;
  localparam int photon_x      = 60;
  localparam int photon_y      = 2;
  localparam int accum_x       = 40;
  localparam int accum_y       = 2;

  // Write counts per command, for the time limits.
  localparam int clear_writes = screen_width * screen_height;
  localparam int frame_writes = 2 * (screen_width - 2 * frame_margin) +
                                3 * (screen_height - 2 * frame_margin);
  localparam int glyph_writes = digit_count * glyph_cols * glyph_bits;
  localparam int all_writes   = clear_writes + frame_writes + 3 * glyph_writes;
  localparam int watchdog_cycles = all_writes * 6 + 1000;  // Six cycles per write worst case.

  logic        clk;
  logic        rst_n;
  logic        en;
  cmd_t        cmd;
  logic [31:0] data;
  logic        draw_done;
  pix_addr_t   wr_addr;
  color_t      wr_data;
  logic        wr_req;
  logic        wr_done = 1'b0;

  integer      seed        = 92;
  int          stim_errors = 0;
  int          wait_left   = 0;     // SDRAM latency still to go.
  logic        pending     = 1'b0;  // Latency drawn for this request.
  int          error_total;
  logic [31:0] accum_word;

  draw_core #(
    .screen_width  (screen_width),
    .screen_height (screen_height),
    .frame_margin  (frame_margin),
    .photon_x      (photon_x),
    .photon_y      (photon_y),
    .accum_x       (accum_x),
    .accum_y       (accum_y)
  ) dut_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .en        (en),
    .cmd       (cmd),
    .data      (data),
    .draw_done (draw_done),
    .wr_addr   (wr_addr),
    .wr_data   (wr_data),
    .wr_req    (wr_req),
    .wr_done   (wr_done)
  );

  draw_checker #(
    .screen_width  (screen_width),
    .screen_height (screen_height),
    .frame_margin  (frame_margin),
    .photon_x      (photon_x),
    .photon_y      (photon_y),
    .accum_x       (accum_x),
    .accum_y       (accum_y)
  ) chk_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .en        (en),
    .cmd       (cmd),
    .data      (data),
    .draw_done (draw_done),
    .wr_addr   (wr_addr),
    .wr_data   (wr_data),
    .wr_req    (wr_req),
    .wr_done   (wr_done)
  );

  bind draw_core draw_core_properties props_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .wr_req    (wr_req),
    .wr_addr   (wr_addr),
    .wr_data   (wr_data),
    .wr_done   (wr_done),
    .draw_done (draw_done)
  );

  always #(clk_period / 2) clk = ~clk;

  //////////////////////////////////////////////////
  // SDRAM responder. Zero to three cycles per write.
  always @(negedge clk) begin
    if (!rst_n) begin
      wr_done <= 1'b0;
      pending = 1'b0;
    end else if (wr_done) begin
      wr_done <= 1'b0;                             // One-cycle pulse.
    end else if (wr_req) begin
      if (!pending) begin
        wait_left = $unsigned($random(seed)) % 4;
        pending   = 1'b1;
      end
      if (wait_left == 0) begin
        wr_done <= 1'b1;
        pending = 1'b0;
      end else begin
        wait_left = wait_left - 1;
      end
    end
  end

  // One command, then wait for its draw_done.
  task automatic run_command(input cmd_t code, input logic [31:0] word, input int writes);
    int   waited;
    logic seen;
    waited = 0;
    seen   = 1'b0;
    @(negedge clk);
    en   = 1'b1;
    cmd  = code;
    data = word;
    @(negedge clk);
    en = 1'b0;
    while (!seen && waited < writes * 6 + 50) begin
      @(negedge clk);
      seen = draw_done;
      waited++;
    end
    if (!seen) begin
      $display("No draw_done for command %0d within %0d cycles", code, waited);
      stim_errors++;
    end
  endtask

  // Unknown code must leave the bus quiet.
  task automatic check_ignored(input logic [3:0] code);
    int stray;
    stray = 0;
    @(negedge clk);
    en   = 1'b1;
    cmd  = cmd_t'(code);
    data = 32'hffff_ffff;
    @(negedge clk);
    en = 1'b0;
    repeat (20) begin
      @(negedge clk);
      if (wr_req || draw_done)
        stray++;
    end
    if (stray != 0) begin
      $display("Unknown command %0d caused activity on %0d cycles", code, stray);
      stim_errors++;
    end
  endtask

  //////////////////////////////////////////////////
  // Stimulus.
  initial begin
    clk   = 1'b0;
    rst_n = 1'b0;
    en    = 1'b0;
    cmd   = cmd_clear;
    data  = 32'h0;
    repeat (5) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    run_command(cmd_clear, 32'h0, clear_writes);
    run_command(cmd_frame, 32'h0, frame_writes);
    run_command(cmd_photon, 32'h0123_4567, glyph_writes);
    accum_word        = $random(seed);
    accum_word[31:28] = 4'hc;                      // Blank glyphs in the word.
    accum_word[11:8]  = 4'hf;
    run_command(cmd_accum, accum_word, glyph_writes);
    check_ignored(4'd3);
    run_command(cmd_photon, 32'h9081_7263, glyph_writes);  // Still accepted.

    repeat (5) @(negedge clk);
    error_total = chk_i.value_errors + chk_i.protocol_errors + stim_errors;
    $display("Checked %0d writes, errors %0d value, %0d protocol, %0d stimulus",
             chk_i.writes_seen, chk_i.value_errors, chk_i.protocol_errors, stim_errors);
    if (error_total == 0)
      $display("*** PASSED ***");
    else
      $display("*** FAILED ***");
    $finish;
  end

  // Watchdog.
  initial begin
    #(clk_period * watchdog_cycles);
    $display("Timeout after %0d cycles, the run did not finish", watchdog_cycles);
    $display("*** FAILED ***");
    $finish;
  end

endmodule

`default_nettype wire

/* glyph/digit_font.hex */
// One font byte per line, eight lines per digit, digits 0 to 9 in order.
// Byte c is glyph row c; bit 0 is the rightmost pixel of that row.
3c  // Digit 0.
66
6e
76
66
66
3c
00
18  // Digit 1.
38
18
18
18
18
7e
00
3c  // Digit 2.
66
06
0c
30
60
7e
00
3c  // Digit 3.
66
06
1c
06
66
3c
00
0c  // Digit 4.
1c
3c
6c
7e
0c
0c
00
7e  // Digit 5.
60
7c
06
06
66
3c
00
3c  // Digit 6.
60
7c
66
66
66
3c
00
7e  // Digit 7.
06
0c
18
30
30
30
00
3c  // Digit 8.
66
66
3c
66
66
3c
00
3c  // Digit 9.
66
66
3e
06
0c
38
00

/* draw_core.f */
common/draw_pkg.sv
glyph/font_rom.sv
glyph/glyph_engine.sv
raster/span_engine.sv
verilog/pixel_writer.sv
verilog/draw_cmd_decode.sv
verilog/draw_core.sv
bench/draw_checker.sv
bench/draw_core_properties.sv
bench/draw_core_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Compile and run the draw_core testbench with Verilator.
cd "$(dirname "$0")" || exit 1

log=sim.log
rm -rf obj_dir "$log"

verilator --binary --timing --assert -Wno-fatal \
  --top-module draw_core_tb -f draw_core.f > "$log" 2>&1 \
  && ./obj_dir/Vdraw_core_tb >> "$log" 2>&1 \
  || echo "*** FAILED ***" >> "$log"

cat "$log"

# A build error, a crash or a failed check all leave the fail line.
grep -qF "*** FAILED ***" "$log" && exit 1 || exit 0
